//--- src/noc_bridge_consts.svh
/*
 * bridge-wide constants
 * address and data widths, request queue depth, header flit count
 */
`ifndef NOC_BRIDGE_CONSTS_SVH
`define NOC_BRIDGE_CONSTS_SVH

// physical address carried in the second header flit
`define BRIDGE_ADDR_WIDTH 48

// AXI-lite data word, one NoC flit wide
`define BRIDGE_DATA_WIDTH 64

// log2 of the entries in each request queue
`define BRIDGE_QUEUE_DEPTH_LOG2 2

// every request packet opens with this many header flits
`define BRIDGE_HDR_FLITS 3

`endif

//--- src/axil_pkg.sv
/*
 * AXI-lite side types
 * address, data, strobe and response words, queued write entry, request kind
 */
`default_nettype none

`include "noc_bridge_consts.svh"

package axil_pkg;

    typedef logic [`BRIDGE_ADDR_WIDTH-1:0]   axil_addr_t;
    typedef logic [`BRIDGE_DATA_WIDTH-1:0]   axil_data_t;
    typedef logic [`BRIDGE_DATA_WIDTH/8-1:0] axil_strb_t;  // one bit per byte lane
    typedef logic [1:0]                      axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    // W channel beat as held in the write data queue
    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
    } wr_entry_t;

    // which queue the current packet is built from
    typedef enum logic {
        REQ_LOAD  = 1'b0,
        REQ_STORE = 1'b1
    } req_kind_e;

endpackage

`default_nettype wire

//--- src/noc_msg_pkg.sv
/*
 * NoC side types
 * flit, node id, message codes, the three header flit layouts, packet phase
 */
`default_nettype none

`include "noc_bridge_consts.svh"

package noc_msg_pkg;

    typedef logic [`BRIDGE_DATA_WIDTH-1:0] noc_flit_t;

    typedef struct packed {
        logic [13:0] chip;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [3:0]  fbits;
    } node_id_t;

    typedef enum logic [7:0] {
        NC_LOAD_REQ  = 8'd14,
        NC_STORE_REQ = 8'd15,
        LOAD_ACK     = 8'd24,  // answers come back with these two
        STORE_ACK    = 8'd25
    } msg_type_e;

    // ========================================================================
    // header flit layouts, msb first
    // ========================================================================
    typedef struct packed {
        node_id_t    dst;
        logic [7:0]  length;    // flits after this one
        msg_type_e   msg_type;
        logic [7:0]  mshrid;
        logic [5:0]  options;
    } hdr1_t;

    typedef struct packed {
        logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
        logic [2:0]                    data_size;
        logic [7:0]                    mask;
        logic [4:0]                    rsvd;
    } hdr2_t;

    typedef struct packed {
        node_id_t    src;
        logic [29:0] rsvd;
    } hdr3_t;

    localparam logic [2:0] DATA_SIZE_8B = 3'd3;
    localparam logic [7:0] LOAD_LEN     = 8'd2;
    localparam logic [7:0] STORE_LEN    = 8'd3;  // two headers plus the data flit

    typedef enum logic [2:0] {
        PH_NONE,
        PH_HDR1,
        PH_HDR2,
        PH_HDR3,
        PH_DATA
    } pkt_phase_e;

endpackage

`default_nettype wire

//--- src/req_fifo.sv
/*
 * req_fifo
 * synchronous circular request queue, width set by parameter
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_bridge_consts.svh"

module req_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = `BRIDGE_QUEUE_DEPTH_LOG2;
    localparam int DEPTH = 1 << PTR_W;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // overflow is dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    assign rdata = mem[rd_ptr];  // head, valid while not empty
    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire

//--- src/flit_counter.sv
/*
 * flit_counter
 * index of the header flit in flight, flags the last one
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_bridge_consts.svh"

module flit_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       advance,
    output logic [1:0] flit_idx,
    output logic       last_hdr
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_idx <= 2'd0;
        end else if (clear) begin
            flit_idx <= 2'd0;  // clear wins over advance
        end else if (advance) begin
            flit_idx <= flit_idx + 2'd1;
        end
    end

    assign last_hdr = (flit_idx == 2'(`BRIDGE_HDR_FLITS - 1));

endmodule

`default_nettype wire

//--- src/flit_sequencer.sv
/*
 * flit_sequencer
 * packet FSM, picks load or store, paces flits, pops the queues
 */
`timescale 1ns/1ps
`default_nettype none

module flit_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ar_empty,
    input  logic                    aw_empty,
    input  logic                    w_empty,
    input  logic                    noc_ready,
    input  logic [1:0]              flit_idx,
    input  logic                    last_hdr,
    output axil_pkg::req_kind_e     kind,
    output noc_msg_pkg::pkt_phase_e phase,
    output logic                    noc_valid,
    output logic                    cnt_clear,
    output logic                    cnt_advance,
    output logic                    ar_pop,
    output logic                    aw_pop,
    output logic                    w_pop
);
    import axil_pkg::*;
    import noc_msg_pkg::*;

    typedef enum logic [1:0] {IDLE, HEADER, DATA} seq_state_e;

    seq_state_e state;
    seq_state_e state_next;
    req_kind_e  kind_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            kind  <= REQ_LOAD;
        end else begin
            state <= state_next;
            kind  <= kind_next;
        end
    end

    // ========================================================================
    // next state and flit pacing
    // ========================================================================
    always_comb begin
        state_next  = state;
        kind_next   = kind;
        phase       = PH_NONE;
        noc_valid   = 1'b0;
        cnt_clear   = 1'b0;
        cnt_advance = 1'b0;
        ar_pop      = 1'b0;
        aw_pop      = 1'b0;
        w_pop       = 1'b0;
        unique case (state)
            IDLE: begin
                cnt_clear = 1'b1;
                if (!ar_empty) begin             // reads go first
                    kind_next  = REQ_LOAD;
                    state_next = HEADER;
                end else if (!aw_empty && !w_empty) begin
                    kind_next  = REQ_STORE;
                    state_next = HEADER;
                end
            end
            HEADER: begin
                noc_valid = 1'b1;
                case (flit_idx)
                    2'd0:    phase = PH_HDR1;
                    2'd1:    phase = PH_HDR2;
                    default: phase = PH_HDR3;
                endcase
                if (noc_ready && last_hdr) begin
                    cnt_clear = 1'b1;
                    if (kind == REQ_LOAD) begin
                        ar_pop     = 1'b1;       // load is complete after its headers
                        state_next = IDLE;
                    end else begin
                        state_next = DATA;
                    end
                end else if (noc_ready) begin
                    cnt_advance = 1'b1;
                end
            end
            DATA: begin
                phase     = PH_DATA;
                noc_valid = 1'b1;
                if (noc_ready) begin
                    aw_pop     = 1'b1;
                    w_pop      = 1'b1;
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- src/flit_builder.sv
/*
 * flit_builder
 * combinational flit assembly from the selected request and the phase
 */
`timescale 1ns/1ps
`default_nettype none

module flit_builder (
    input  axil_pkg::req_kind_e     kind,
    input  noc_msg_pkg::pkt_phase_e phase,
    input  axil_pkg::axil_addr_t    ar_addr,
    input  axil_pkg::axil_addr_t    aw_addr,
    input  axil_pkg::wr_entry_t     wr,
    input  noc_msg_pkg::node_id_t   src_node,
    input  noc_msg_pkg::node_id_t   dst_node,
    output noc_msg_pkg::noc_flit_t  flit
);
    import axil_pkg::*;
    import noc_msg_pkg::*;

    hdr1_t      hdr1;
    hdr2_t      hdr2;
    hdr3_t      hdr3;
    logic       is_store;
    axil_strb_t mask_rev;
    axil_data_t data_rev;

    assign is_store = (kind == REQ_STORE);
    assign mask_rev = {<<{wr.strb}};     // strobe bit 0 ends up in mask bit 7
    assign data_rev = {<<8{wr.data}};    // byte swap for the NoC

    // ========================================================================
    // header fields
    // ========================================================================
    always_comb begin
        hdr1.dst      = dst_node;
        hdr1.length   = is_store ? STORE_LEN : LOAD_LEN;
        hdr1.msg_type = is_store ? NC_STORE_REQ : NC_LOAD_REQ;
        hdr1.mshrid   = 8'd0;
        hdr1.options  = 6'd0;

        hdr2.addr      = is_store ? aw_addr : ar_addr;
        hdr2.data_size = DATA_SIZE_8B;
        hdr2.mask      = is_store ? mask_rev : 8'd0;  // loads carry no mask
        hdr2.rsvd      = 5'd0;

        hdr3.src  = src_node;
        hdr3.rsvd = 30'd0;
    end

    always_comb begin
        unique case (phase)
            PH_HDR1: flit = noc_flit_t'(hdr1);
            PH_HDR2: flit = noc_flit_t'(hdr2);
            PH_HDR3: flit = noc_flit_t'(hdr3);
            PH_DATA: flit = data_rev;
            default: flit = '0;                       // nothing on the wire
        endcase
    end

endmodule

`default_nettype wire

//--- src/noc_resp_unpacker.sv
/*
 * noc_resp_unpacker
 * consumes NoC acknowledgements, drives the AXI-lite B and R channels
 */
`timescale 1ns/1ps
`default_nettype none

module noc_resp_unpacker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   noc_valid_in,
    input  noc_msg_pkg::noc_flit_t noc_data_in,
    output logic                   noc_ready_out,
    output logic                   bvalid,
    output axil_pkg::axil_resp_t   bresp,
    input  logic                   bready,
    output logic                   rvalid,
    output axil_pkg::axil_data_t   rdata,
    output axil_pkg::axil_resp_t   rresp,
    input  logic                   rready
);
    import axil_pkg::*;
    import noc_msg_pkg::*;

    typedef enum logic [2:0] {
        WAIT_HDR,
        LOAD_DATA,
        SKIP,
        B_PEND,
        R_PEND
    } unpack_state_e;

    unpack_state_e state;
    hdr1_t         hdr;
    logic [7:0]    skip_cnt;   // flits still to drop
    logic          accept;

    assign hdr           = hdr1_t'(noc_data_in);
    assign noc_ready_out = (state != B_PEND) && (state != R_PEND);  // hold off while a response waits
    assign accept        = noc_valid_in && noc_ready_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= WAIT_HDR;
            skip_cnt <= 8'd0;
        end else begin
            unique case (state)
                WAIT_HDR: begin
                    if (accept) begin
                        if (hdr.msg_type == STORE_ACK) begin
                            state <= B_PEND;
                        end else if (hdr.msg_type == LOAD_ACK) begin
                            state <= LOAD_DATA;
                        end else if (hdr.length != 8'd0) begin
                            skip_cnt <= hdr.length;  // unknown message, drop its body
                            state    <= SKIP;
                        end
                    end
                end
                LOAD_DATA: if (accept) state <= R_PEND;
                SKIP: begin
                    if (accept) begin
                        skip_cnt <= skip_cnt - 8'd1;
                        if (skip_cnt == 8'd1) state <= WAIT_HDR;
                    end
                end
                B_PEND:  if (bready) state <= WAIT_HDR;
                R_PEND:  if (rready) state <= WAIT_HDR;
                default: state <= WAIT_HDR;
            endcase
        end
    end

    // read data back in AXI byte order
    always_ff @(posedge clk) begin
        if (state == LOAD_DATA && accept) rdata <= {<<8{noc_data_in}};
    end

    assign bvalid = (state == B_PEND);
    assign rvalid = (state == R_PEND);
    assign bresp  = RESP_OKAY;
    assign rresp  = RESP_OKAY;

endmodule

`default_nettype wire

//--- src/axil_noc_bridge.sv
/*
 * axil_noc_bridge
 * top level, request queues, packet sequencer, flit builder, response unpacker
 */
`timescale 1ns/1ps
`default_nettype none

module axil_noc_bridge (
    input  logic                   clk,
    input  logic                   rst_n,
    input  noc_msg_pkg::node_id_t  src_node,
    input  noc_msg_pkg::node_id_t  dst_node,
    // write address
    input  axil_pkg::axil_addr_t   awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    // write data
    input  axil_pkg::axil_data_t   wdata,
    input  axil_pkg::axil_strb_t   wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    // read address
    input  axil_pkg::axil_addr_t   araddr,
    input  logic                   arvalid,
    output logic                   arready,
    // write response
    output axil_pkg::axil_resp_t   bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // read data
    output axil_pkg::axil_data_t   rdata,
    output axil_pkg::axil_resp_t   rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // NoC request port
    output logic                   noc_valid_out,
    output noc_msg_pkg::noc_flit_t noc_data_out,
    input  logic                   noc_ready_in,
    // NoC acknowledgement port
    input  logic                   noc_valid_in,
    input  noc_msg_pkg::noc_flit_t noc_data_in,
    output logic                   noc_ready_out
);
    import axil_pkg::*;
    import noc_msg_pkg::*;

    axil_addr_t aw_head, ar_head;
    wr_entry_t  w_in, w_head;
    logic       aw_full, aw_empty, aw_pop;
    logic       w_full, w_empty, w_pop;
    logic       ar_full, ar_empty, ar_pop;
    logic [1:0] flit_idx;
    logic       last_hdr, cnt_clear, cnt_advance;
    req_kind_e  kind;
    pkt_phase_e phase;

    assign awready = !aw_full;
    assign wready  = !w_full;
    assign arready = !ar_full;
    assign w_in    = '{data: wdata, strb: wstrb};

    // ========================================================================
    // request queues, one push per AXI-lite transfer
    // ========================================================================
    req_fifo #(.WIDTH($bits(axil_addr_t))) aw_q (
        .clk(clk), .rst_n(rst_n), .push(awvalid && awready), .wdata(awaddr),
        .pop(aw_pop), .rdata(aw_head), .full(aw_full), .empty(aw_empty)
    );
    req_fifo #(.WIDTH($bits(wr_entry_t))) w_q (
        .clk(clk), .rst_n(rst_n), .push(wvalid && wready), .wdata(w_in),
        .pop(w_pop), .rdata(w_head), .full(w_full), .empty(w_empty)
    );
    req_fifo #(.WIDTH($bits(axil_addr_t))) ar_q (
        .clk(clk), .rst_n(rst_n), .push(arvalid && arready), .wdata(araddr),
        .pop(ar_pop), .rdata(ar_head), .full(ar_full), .empty(ar_empty)
    );

    flit_counter u_counter (
        .clk(clk), .rst_n(rst_n), .clear(cnt_clear), .advance(cnt_advance),
        .flit_idx(flit_idx), .last_hdr(last_hdr)
    );

    flit_sequencer u_sequencer (
        .clk(clk), .rst_n(rst_n),
        .ar_empty(ar_empty), .aw_empty(aw_empty), .w_empty(w_empty),
        .noc_ready(noc_ready_in), .flit_idx(flit_idx), .last_hdr(last_hdr),
        .kind(kind), .phase(phase), .noc_valid(noc_valid_out),
        .cnt_clear(cnt_clear), .cnt_advance(cnt_advance),
        .ar_pop(ar_pop), .aw_pop(aw_pop), .w_pop(w_pop)
    );

    flit_builder u_builder (
        .kind(kind), .phase(phase), .ar_addr(ar_head), .aw_addr(aw_head), .wr(w_head),
        .src_node(src_node), .dst_node(dst_node), .flit(noc_data_out)
    );

    noc_resp_unpacker u_unpacker (
        .clk(clk), .rst_n(rst_n),
        .noc_valid_in(noc_valid_in), .noc_data_in(noc_data_in), .noc_ready_out(noc_ready_out),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
    );

endmodule

`default_nettype wire

//--- tests/tb_tasks.svh
/*
 * directed tests for the bridge testbench
 * expected flit builders, AXI-lite request driver, NoC ack source, B and R checks
 */

// ============================================================================
// expected flits, built from the packet format
// ============================================================================
function automatic noc_flit_t swap_bytes(input logic [63:0] d);
    noc_flit_t r;
    for (int i = 0; i < 8; i++) begin
        r[8*i +: 8] = d[8*(7-i) +: 8];
    end
    return r;
endfunction

function automatic noc_flit_t req_hdr1(input logic is_store);
    hdr1_t h;
    h          = '0;
    h.dst      = dst_node;
    h.length   = is_store ? 8'd3 : 8'd2;
    h.msg_type = is_store ? NC_STORE_REQ : NC_LOAD_REQ;
    return noc_flit_t'(h);
endfunction

function automatic noc_flit_t req_hdr2(input axil_addr_t addr, input axil_strb_t strb);
    hdr2_t h;
    h           = '0;
    h.addr      = addr;
    h.data_size = 3'd3;                 // 8 byte access
    for (int i = 0; i < 8; i++) begin
        h.mask[7-i] = strb[i];
    end
    return noc_flit_t'(h);
endfunction

function automatic noc_flit_t req_hdr3();
    hdr3_t h;
    h     = '0;
    h.src = src_node;
    return noc_flit_t'(h);
endfunction

function automatic noc_flit_t ack_hdr(input logic [7:0] msg, input logic [7:0] len);
    hdr1_t h;
    h          = '0;
    h.dst      = src_node;              // acks travel back to the bridge tile
    h.length   = len;
    h.msg_type = msg_type_e'(msg);
    return noc_flit_t'(h);
endfunction

task automatic expect_load(input axil_addr_t addr);
    exp_flits.push_back(req_hdr1(1'b0));
    exp_flits.push_back(req_hdr2(addr, 8'h00));
    exp_flits.push_back(req_hdr3());
endtask

task automatic expect_store(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    exp_flits.push_back(req_hdr1(1'b1));
    exp_flits.push_back(req_hdr2(addr, strb));
    exp_flits.push_back(req_hdr3());
    exp_flits.push_back(swap_bytes(data));
endtask

// ============================================================================
// drivers and response checks
// ============================================================================
task automatic issue_requests(input logic do_rd, input axil_addr_t rd_addr,
                              input logic do_wr, input axil_addr_t wr_addr,
                              input axil_data_t data, input axil_strb_t strb);
    int   cycles;
    logic ar_done, aw_done, w_done;
    cycles  = 0;
    ar_done = !do_rd;
    aw_done = !do_wr;
    w_done  = !do_wr;
    arvalid = do_rd;
    araddr  = rd_addr;
    awvalid = do_wr;
    awaddr  = wr_addr;
    wvalid  = do_wr;
    wdata   = data;
    wstrb   = strb;
    while (!(ar_done && aw_done && w_done)) begin
        @(negedge clk);
        ar_done = ar_done || arready;   // transfer on the coming edge
        aw_done = aw_done || awready;
        w_done  = w_done || wready;
        @(posedge clk);
        #2;
        if (ar_done) arvalid = 1'b0;
        if (aw_done) awvalid = 1'b0;
        if (w_done)  wvalid = 1'b0;
        cycles++;
        if (cycles > TIMEOUT_CYCLES) report_error("timeout waiting for an AXI-lite ready");
    end
endtask

task automatic check_flits();
    int cycles;
    cycles = 0;
    while (got_flits.size() < exp_flits.size()) begin
        @(posedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) report_error("timeout waiting for NoC request flits");
    end
    repeat (QUIET_CYCLES) @(posedge clk);   // a duplicated flit would land here
    #2;
    assert (got_flits.size() == exp_flits.size())
        else value_error("flit_count", exp_flits.size(), got_flits.size());
    foreach (exp_flits[i]) begin
        assert (got_flits[i] === exp_flits[i])
            else value_error("noc_data_out", exp_flits[i], got_flits[i]);
    end
    got_flits.delete();
    exp_flits.delete();
endtask

task automatic send_flit(input noc_flit_t f);
    int   cycles;
    logic taken;
    cycles       = 0;
    taken        = 1'b0;
    noc_valid_in = 1'b1;
    noc_data_in  = f;
    while (!taken) begin
        @(negedge clk);
        taken = noc_ready_out;
        @(posedge clk);
        #2;
        cycles++;
        if (!taken && cycles > TIMEOUT_CYCLES) report_error("timeout waiting for noc_ready_out");
    end
    noc_valid_in = 1'b0;
    noc_data_in  = '0;
endtask

task automatic expect_b();
    int cycles;
    cycles = 0;
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) report_error("timeout waiting for bvalid");
        @(negedge clk);
    end
    assert (bresp === 2'b00) else value_error("bresp", 2'b00, bresp);
    @(posedge clk);
    #2;
    bready = 1'b0;
endtask

task automatic expect_r(input axil_data_t exp);
    int cycles;
    cycles = 0;
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) report_error("timeout waiting for rvalid");
        @(negedge clk);
    end
    assert (rdata === exp) else value_error("rdata", exp, rdata);
    assert (rresp === 2'b00) else value_error("rresp", 2'b00, rresp);
    @(posedge clk);
    #2;
    rready = 1'b0;
endtask

task automatic expect_silence();
    repeat (QUIET_CYCLES) begin
        @(negedge clk);
        assert (!bvalid && !rvalid)
            else report_error("B or R response raised for an unknown acknowledgement");
    end
    @(posedge clk);
    #2;
endtask

task automatic check_reset_state();
    @(negedge clk);
    assert (noc_valid_out === 1'b0) else value_error("noc_valid_out", 0, noc_valid_out);
    assert (bvalid === 1'b0) else value_error("bvalid", 0, bvalid);
    assert (rvalid === 1'b0) else value_error("rvalid", 0, rvalid);
    assert (noc_ready_out === 1'b1) else value_error("noc_ready_out", 1, noc_ready_out);
    // empty queues accept on every channel
    assert (awready === 1'b1) else value_error("awready", 1, awready);
    assert (wready === 1'b1) else value_error("wready", 1, wready);
    assert (arready === 1'b1) else value_error("arready", 1, arready);
    @(posedge clk);
    #2;
endtask

// ============================================================================
// directed tests
// ============================================================================
task automatic test_store();
    expect_store(48'h0000_8000_1040, 64'h1122_3344_5566_7788, 8'h35);
    issue_requests(1'b0, '0, 1'b1, 48'h0000_8000_1040, 64'h1122_3344_5566_7788, 8'h35);
    check_flits();
    send_flit(ack_hdr(STORE_ACK, 8'd0));
    expect_b();
endtask

task automatic test_load();
    expect_load(48'h0000_abcd_0040);
    issue_requests(1'b1, 48'h0000_abcd_0040, 1'b0, '0, '0, '0);
    check_flits();
    send_flit(ack_hdr(LOAD_ACK, 8'd1));
    send_flit(64'h0102_0304_0506_0708);
    expect_r(64'h0807_0605_0403_0201);
endtask

// read wins when both arrive together
task automatic test_read_write_order();
    expect_load(48'h0000_0000_3000);
    expect_store(48'h0000_0000_4000, 64'hcafe_f00d_0bad_beef, 8'hff);
    issue_requests(1'b1, 48'h0000_0000_3000, 1'b1, 48'h0000_0000_4000,
                   64'hcafe_f00d_0bad_beef, 8'hff);
    check_flits();
endtask

task automatic test_backpressure();
    axil_addr_t addr [3];
    axil_data_t data [3];
    axil_strb_t strb [3];
    for (int i = 0; i < 3; i++) begin
        addr[i] = 48'h0000_2000_0000 + 48'(i * 8);
        data[i] = {$random(seed), $random(seed)};
        strb[i] = 8'($random(seed));
        expect_store(addr[i], data[i], strb[i]);
    end
    rand_ready = 1'b1;
    for (int i = 0; i < 3; i++) begin
        issue_requests(1'b0, '0, 1'b1, addr[i], data[i], strb[i]);
    end
    check_flits();
    rand_ready = 1'b0;
endtask

task automatic test_unknown_ack();
    send_flit(ack_hdr(8'h07, 8'd1));
    // body shaped like a store ack, raises bvalid unless it is skipped
    send_flit(ack_hdr(STORE_ACK, 8'd0));
    expect_silence();
    send_flit(ack_hdr(STORE_ACK, 8'd0));
    expect_b();
endtask

//--- tests/tb_axil_noc_bridge.sv
/*
 * testbench top for the AXI-lite to NoC bridge
 * clock and reset, DUT instance, NoC ready driver and flit monitor, test sequence
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_noc_bridge;
    import axil_pkg::*;
    import noc_msg_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES   = 20;

    logic       clk;
    logic       rst_n;
    node_id_t   src_node;
    node_id_t   dst_node;
    axil_addr_t awaddr;
    logic       awvalid, awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid, wready;
    axil_addr_t araddr;
    logic       arvalid, arready;
    axil_resp_t bresp;
    logic       bvalid, bready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid, rready;
    logic       noc_valid_out, noc_ready_in;
    noc_flit_t  noc_data_out;
    logic       noc_valid_in, noc_ready_out;
    noc_flit_t  noc_data_in;

    integer      seed;
    logic        rand_ready;        // random back-pressure on the NoC output
    logic [31:0] rnd;
    noc_flit_t   got_flits[$];
    noc_flit_t   exp_flits[$];
    logic        stalled;
    noc_flit_t   stall_flit;

    axil_noc_bridge uut (
        .clk(clk), .rst_n(rst_n), .src_node(src_node), .dst_node(dst_node),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .noc_valid_out(noc_valid_out), .noc_data_out(noc_data_out),
        .noc_ready_in(noc_ready_in),
        .noc_valid_in(noc_valid_in), .noc_data_in(noc_data_in),
        .noc_ready_out(noc_ready_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================================================
    // error reporting
    // ========================================================================
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic value_error(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act);
        abort_run();
    endtask

    // NoC output ready, changes just after the rising edge
    always @(posedge clk) begin
        #2;
        if (rand_ready) begin
            rnd          = $random(seed);
            noc_ready_in = rnd[0];
        end else begin
            noc_ready_in = 1'b1;
        end
    end

    // collect accepted flits mid-cycle, a stalled flit has to hold
    always @(negedge clk) begin
        if (stalled) begin
            assert (noc_valid_out && noc_data_out === stall_flit)
                else report_error("NoC output flit dropped or changed while stalled");
        end
        if (rst_n && noc_valid_out && noc_ready_in) got_flits.push_back(noc_data_out);
        stalled    = rst_n && noc_valid_out && !noc_ready_in;
        stall_flit = noc_data_out;
    end

    initial begin
        seed         = 32'h7571;
        rand_ready   = 1'b0;
        stalled      = 1'b0;
        rst_n        = 1'b0;
        src_node     = '{chip: 14'd1, x: 8'd2, y: 8'd3, fbits: 4'd0};
        dst_node     = '{chip: 14'd5, x: 8'd6, y: 8'd7, fbits: 4'd9};
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        bready       = 1'b0;
        rready       = 1'b0;
        noc_ready_in = 1'b1;
        noc_valid_in = 1'b0;
        noc_data_in  = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_reset_state();
        test_store();
        test_load();
        test_read_write_order();
        test_backpressure();
        test_unknown_ack();

        $display("Test passed");
        $finish;
    end

    `include "tb_tasks.svh"

endmodule

`default_nettype wire

//--- project.f
+incdir+src
+incdir+tests
src/axil_pkg.sv
src/noc_msg_pkg.sv
src/req_fifo.sv
src/flit_counter.sv
src/flit_sequencer.sv
src/flit_builder.sv
src/noc_resp_unpacker.sv
src/axil_noc_bridge.sv
tests/tb_axil_noc_bridge.sv
